/* project.f */
design/disp_types_pkg.sv
design/disp_timing_pkg.sv
design/tick_gen.sv
design/bcd_convert.sv
design/digit_frame.sv
design/seg_scan.sv
design/display_top.sv
dv/display_assert.sv
dv/display_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= display_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  := *** TEST PASSED ***

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) $(SIM_ARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* dv/display_tb.sv */
`timescale 1ns/1ps

module display_tb;

  import disp_types_pkg::*;
  import disp_timing_pkg::*;

  localparam int scan_div    = 4;
  localparam int blink_div   = 64;
  localparam int num_values  = 20;
  // Values, two blink periods and a margin
  localparam int cycle_limit = num_values * 30 + 2 * (2 * blink_div) + 200;

  logic        clk;
  logic        rst_n;
  logic        value_valid;
  value_t      value_data;
  logic        blink_en;
  logic [15:0] leds;
  logic        credit_return;
  logic [7:0]  seg_en;
  logic [7:0]  seg_out;
  logic [16:0] led_out;

  int          seed;
  int          cycles;
  int          credits;
  int          credit_pulses;
  int          toggles;
  int          dark;
  logic        prev_blink;
  logic [31:0] rnd_a;
  logic [31:0] rnd_b;

  display_top #(
    .scan_div  (scan_div),
    .blink_div (blink_div)
  ) u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .value_valid   (value_valid),
    .value_data    (value_data),
    .blink_en      (blink_en),
    .leds          (leds),
    .credit_return (credit_return),
    .seg_en        (seg_en),
    .seg_out       (seg_out),
    .led_out       (led_out)
  );

  bind display_top display_assert #(
    .scan_div (scan_div)
  ) u_assert (
    .clk           (clk),
    .rst_n         (rst_n),
    .value_valid   (value_valid),
    .credit_return (credit_return),
    .blink_en      (blink_en),
    .leds          (leds),
    .seg_en        (seg_en),
    .seg_out       (seg_out),
    .led_out       (led_out),
    .scan_tick     (scan_tick),
    .frame         (frame)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic check_equal(string name, logic [31:0] exp, logic [31:0] act);
    assert (act == exp) else begin
      $display("error %s expected %h actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // One clock; all inputs move on the falling edge
  task automatic step();
    @(negedge clk);
    cycles++;
    if (credit_return) begin
      credits++;
      credit_pulses++;
    end
    leds = 16'($random(seed));
    if (u_dut.u_assert.err_count != 0) begin
      $display("bound checker reported a rule violation, see the message above");
      abort_run();
    end else if (cycles > cycle_limit) begin
      $display("timeout: run went past %0d cycles", cycle_limit);
      abort_run();
    end
  endtask

  // Decimal digits of the magnitude, sign on the left, leading zeros dark
  function automatic frame_t expected_frame(value_t val);
    frame_t f;
    longint mag;
    logic   seen;
    mag  = (val < 0) ? -longint'(val) : longint'(val);
    seen = 1'b0;
    f.digit[7] = (val < 0) ? glyph_minus : glyph_blank;
    for (int i = 0; i < 7; i++) begin
      f.digit[i] = glyph_t'(4'(mag % 10));
      mag = mag / 10;
    end
    for (int i = 6; i > 0; i--) begin
      if (f.digit[i] != glyph_0) begin
        seen = 1'b1;
      end
      if (!seen) begin
        f.digit[i] = glyph_blank;
      end
    end
    return f;
  endfunction

  task automatic send_value(value_t val);
    while (credits == 0) begin
      step();
    end
    value_valid = 1'b1;
    value_data  = val;
    credits--;
    step();
    value_valid = 1'b0;
  endtask

  // Counts cycles from acceptance to the converter done strobe
  task automatic wait_conversion(output int n);
    n = 0;
    while (!u_dut.conv_valid) begin
      step();
      n++;
    end
    step();
  endtask

  task automatic check_value(string name, value_t val);
    int n;
    send_value(val);
    wait_conversion(n);
    check_equal({name, " latency"}, 32'(conv_cycles + 2), 32'(n));
    check_equal({name, " frame"}, expected_frame(val), u_dut.frame);
  endtask

  task automatic check_pair(string name, value_t a, value_t b);
    int n;
    int pulses0;
    pulses0 = credit_pulses;
    send_value(a);
    send_value(b);
    wait_conversion(n);
    check_equal({name, " first frame"}, expected_frame(a), u_dut.frame);
    wait_conversion(n);
    check_equal({name, " second frame"}, expected_frame(b), u_dut.frame);
    check_equal({name, " credit pulses"}, 32'd2, 32'(credit_pulses - pulses0));
    check_equal({name, " credits"}, 32'(credit_depth), 32'(credits));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 32'h8ba7_c5a4;
    rst_n         = 1'b0;
    value_valid   = 1'b0;
    value_data    = '0;
    blink_en      = 1'b0;
    leds          = '0;
    cycles        = 0;
    credits       = credit_depth;
    credit_pulses = 0;
    toggles       = 0;
    dark          = 0;
    repeat (4) begin
      step();
    end
    rst_n = 1'b1;

    // Quiet outputs before the first tick and value
    repeat (3) begin
      step();
      check_equal("reset seg_en", 32'hff, 32'(seg_en));
      check_equal("reset credit_return", 32'h0, 32'(credit_return));
      check_equal("reset blink bit", 32'h0, 32'(led_out[16]));
    end

    check_value("zero", 24'sd0);
    check_value("single digit", 24'sd7);
    check_value("trailing zero", 24'sd40);
    check_value("five digits", 24'sd12345);
    check_value("million", 24'sd1000000);
    check_value("largest positive", 24'h7f_ffff);
    check_value("minus one", -24'sd1);
    check_value("negative three digits", -24'sd405);
    check_value("negative seven digits", -24'sd7000000);
    check_value("most negative", 24'h80_0000);
    for (int i = 0; i < 6; i++) begin
      rnd_a = $random(seed);
      check_value("random", rnd_a[23:0]);
    end
    for (int i = 0; i < 2; i++) begin
      rnd_a = $random(seed);
      rnd_b = $random(seed);
      check_pair("back to back", rnd_a[23:0], rnd_b[23:0]);
    end

    // Two blink periods, phase flips every blink_div cycles
    blink_en   = 1'b1;
    prev_blink = led_out[16];
    repeat (4 * blink_div) begin
      step();
      if (led_out[16] != prev_blink) begin
        toggles++;
      end
      prev_blink = led_out[16];
    end
    check_equal("blink toggles", 32'd4, 32'(toggles));

    blink_en = 1'b0;
    step();
    repeat (2 * num_digits * scan_div) begin
      step();
      if (seg_en == 8'hff) begin
        dark++;
      end
    end
    check_equal("scan without blink", 32'd0, 32'(dark));

    if (u_dut.u_assert.err_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* dv/display_assert.sv */
`timescale 1ns/1ps

module display_assert #(
  parameter int scan_div = 4
) (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   value_valid,
  input logic                   credit_return,
  input logic                   blink_en,
  input logic [15:0]            leds,
  input logic [7:0]             seg_en,
  input logic [7:0]             seg_out,
  input logic [16:0]            led_out,
  input logic                   scan_tick,
  input disp_types_pkg::frame_t frame
);

  import disp_types_pkg::*;
  import disp_timing_pkg::*;

  int         err_count = 0;
  int         credits;
  int         since_tick;
  logic       tick_seen;
  logic [7:0] en_q;
  frame_t     frame_q;

  // Active-low common anode codes in dp g f e d c b a order
  function automatic logic [7:0] seg_pattern(glyph_t g);
    case (g)
      glyph_0:     return 8'hc0;
      glyph_1:     return 8'hf9;
      glyph_2:     return 8'ha4;
      glyph_3:     return 8'hb0;
      glyph_4:     return 8'h99;
      glyph_5:     return 8'h92;
      glyph_6:     return 8'h82;
      glyph_7:     return 8'hf8;
      glyph_8:     return 8'h80;
      glyph_9:     return 8'h90;
      glyph_minus: return 8'hbf;
      default:     return 8'hff;
    endcase
  endfunction

  // Position of the enabled digit
  function automatic int low_index(logic [7:0] en);
    int idx;
    idx = 0;
    for (int i = 0; i < 8; i++) begin
      if (!en[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credits    <= credit_depth;
      since_tick <= 0;
      tick_seen  <= 1'b0;
      en_q       <= '1;
    end else begin
      // Sender side view of the credit pool
      credits    <= credits - int'(value_valid) + int'(credit_return);
      since_tick <= scan_tick ? 0 : since_tick + 1;
      tick_seen  <= tick_seen | scan_tick;
      en_q       <= seg_en;
    end
  end

  // Frame as the scan stage saw it on the last edge
  always_ff @(posedge clk) begin
    frame_q <= frame;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////////////////////

  a_credit: assert property (@(posedge clk) disable iff (!rst_n)
    (credits >= 0) && (credits <= credit_depth) && (!value_valid || credits > 0))
    else begin
      err_count++;
      $error("credit count out of range or value sent without a credit");
    end

  a_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
    (seg_en == '1) || $onehot(~seg_en))
    else begin
      err_count++;
      $error("more than one digit enabled");
    end

  a_tick_period: assert property (@(posedge clk) disable iff (!rst_n)
    scan_tick && tick_seen |-> since_tick == scan_div - 1)
    else begin
      err_count++;
      $error("scan tick spacing differs from the divider");
    end

  // Enabled digit steps from 7 toward 0 and wraps
  a_rotate: assert property (@(posedge clk) disable iff (!rst_n)
    $past(scan_tick) && (en_q != '1) && (seg_en != '1) |->
      low_index(seg_en) == ((low_index(en_q) == 0) ? num_digits - 1 : low_index(en_q) - 1))
    else begin
      err_count++;
      $error("digit enable did not advance by one position");
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !$past(scan_tick) && !blink_en && !$past(blink_en) |-> seg_en == en_q)
    else begin
      err_count++;
      $error("digit enable changed between scan ticks");
    end

  a_segments: assert property (@(posedge clk) disable iff (!rst_n)
    $past(scan_tick) && (seg_en != '1) |->
      seg_out == seg_pattern(frame_q.digit[low_index(seg_en)]))
    else begin
      err_count++;
      $error("segments do not match the enabled digit");
    end

  a_blink: assert property (@(posedge clk) disable iff (!rst_n)
    (blink_en && !led_out[16] |-> seg_en == '1) and (!blink_en |-> !led_out[16]))
    else begin
      err_count++;
      $error("blink gating or blink indicator wrong");
    end

  a_leds: assert property (@(posedge clk) disable iff (!rst_n)
    led_out[15:0] == leds)
    else begin
      err_count++;
      $error("status LEDs not passed through");
    end

endmodule

/* design/display_top.sv */
`timescale 1ns/1ps

module display_top #(
  parameter int scan_div  = disp_timing_pkg::scan_div_default,
  parameter int blink_div = disp_timing_pkg::blink_div_default
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   value_valid,
  input  disp_types_pkg::value_t                 value_data,
  input  logic                                   blink_en,
  input  logic [15:0]                            leds,
  output logic                                   credit_return,
  output logic [disp_timing_pkg::num_digits-1:0] seg_en,
  output logic [7:0]                             seg_out,
  output logic [16:0]                            led_out
);

  import disp_types_pkg::*;

  logic      conv_valid;
  conv_out_t conv_data;
  frame_t    frame;
  logic      scan_tick;
  logic      blink_phase;

  tick_gen #(
    .scan_div  (scan_div),
    .blink_div (blink_div)
  ) u_tick_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .blink_en    (blink_en),
    .scan_tick   (scan_tick),
    .blink_phase (blink_phase)
  );

  bcd_convert u_bcd_convert (
    .clk           (clk),
    .rst_n         (rst_n),
    .value_valid   (value_valid),
    .value_data    (value_data),
    .credit_return (credit_return),
    .conv_valid    (conv_valid),
    .conv_data     (conv_data)
  );

  digit_frame u_digit_frame (
    .clk        (clk),
    .rst_n      (rst_n),
    .conv_valid (conv_valid),
    .conv_data  (conv_data),
    .frame      (frame)
  );

  seg_scan u_seg_scan (
    .clk         (clk),
    .rst_n       (rst_n),
    .scan_tick   (scan_tick),
    .blink_phase (blink_phase),
    .blink_en    (blink_en),
    .frame       (frame),
    .seg_en      (seg_en),
    .seg_out     (seg_out)
  );

  // Status LEDs pass straight through, blink indicator on top
  assign led_out = {blink_en & blink_phase, leds};

endmodule

/* design/seg_scan.sv */
`timescale 1ns/1ps

module seg_scan (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   scan_tick,
  input  logic                                   blink_phase,
  input  logic                                   blink_en,
  input  disp_types_pkg::frame_t                 frame,
  output logic [disp_timing_pkg::num_digits-1:0] seg_en,
  output logic [7:0]                             seg_out
);

  import disp_types_pkg::*;
  import disp_timing_pkg::*;

  logic [num_digits-1:0] digit_ptr;  // digit lit at the next tick
  logic [num_digits-1:0] digit_on;   // digit lit now, active high
  logic [7:0]            seg_q;
  glyph_t                sel_glyph;
  logic                  blank_all;

  ////////////////////////////////////////////////////////////////////////////
  // Digit select and decode
  ////////////////////////////////////////////////////////////////////////////

  // One-hot pointer picks its glyph
  always_comb begin
    sel_glyph = glyph_blank;
    for (int i = 0; i < num_digits; i++) begin
      if (digit_ptr[i]) begin
        sel_glyph = frame.digit[i];
      end
    end
  end

  // Enable and segments move together on each tick
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      digit_ptr <= {1'b1, {(num_digits - 1){1'b0}}};
      digit_on  <= '0;
      seg_q     <= '1;
    end else if (scan_tick) begin
      digit_on  <= digit_ptr;
      seg_q     <= glyph_to_seg(sel_glyph);
      // Leftmost to rightmost, then back to digit 7
      digit_ptr <= {digit_ptr[0], digit_ptr[num_digits-1:1]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Blink gating
  ////////////////////////////////////////////////////////////////////////////

  // Dark half of the blink turns all digits off at once
  assign blank_all = blink_en & ~blink_phase;

  assign seg_en  = ~digit_on | {num_digits{blank_all}};
  assign seg_out = seg_q;

endmodule

/* design/digit_frame.sv */
`timescale 1ns/1ps

module digit_frame (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      conv_valid,
  input  disp_types_pkg::conv_out_t conv_data,
  output disp_types_pkg::frame_t    frame
);

  import disp_types_pkg::*;
  import disp_timing_pkg::*;

  frame_t frame_next;

  // Build the panel contents from the converter result
  always_comb begin
    logic seen;
    seen = 1'b0;
    // Leftmost position is reserved for the sign
    frame_next.digit[num_digits-1] = conv_data.neg ? glyph_minus : glyph_blank;
    // Blank everything above the first nonzero digit
    for (int i = num_digits - 2; i > 0; i--) begin
      if (conv_data.mag[i] != '0) begin
        seen = 1'b1;
      end
      frame_next.digit[i] = seen ? glyph_t'(conv_data.mag[i]) : glyph_blank;
    end
    // Units digit always shows, so zero reads as 0
    frame_next.digit[0] = glyph_t'(conv_data.mag[0]);
  end

  // Held until the next result
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_digits; i++) begin
        frame.digit[i] <= glyph_blank;
      end
    end else if (conv_valid) begin
      frame <= frame_next;
    end
  end

endmodule

/* design/bcd_convert.sv */
`timescale 1ns/1ps

module bcd_convert (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      value_valid,
  input  disp_types_pkg::value_t    value_data,
  output logic                      credit_return,
  output logic                      conv_valid,
  output disp_types_pkg::conv_out_t conv_data
);

  import disp_types_pkg::*;
  import disp_timing_pkg::*;

  value_t                            fifo_mem [credit_depth];
  logic [$clog2(credit_depth)-1:0]   wr_ptr;
  logic [$clog2(credit_depth)-1:0]   rd_ptr;
  logic [$clog2(credit_depth+1)-1:0] fill;
  logic                              pop;

  conv_state_t                   state;
  value_t                        val_q;
  logic                          neg_q;
  logic [$bits(value_t)-1:0]     bin_q;
  bcd_t [6:0]                    acc_q;
  bcd_t [6:0]                    acc_adj;
  logic [$clog2(conv_cycles)-1:0] shift_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Input buffer
  ////////////////////////////////////////////////////////////////////////////

  // Sender holds a credit for every write, so no full check
  assign pop = (state == conv_idle) && (fill != '0);

  always_ff @(posedge clk) begin
    if (value_valid) begin
      fifo_mem[wr_ptr] <= value_data;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      credit_return <= 1'b0;
    end else begin
      if (value_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({value_valid, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // One credit back per freed entry
      credit_return <= pop;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shift and add-3 conversion
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= conv_idle;
      shift_cnt <= '0;
    end else begin
      case (state)
        conv_idle: begin
          if (pop) begin
            state <= conv_load;
          end
        end
        conv_load: begin
          state     <= conv_shift;
          shift_cnt <= '0;
        end
        conv_shift: begin
          shift_cnt <= shift_cnt + 1'b1;
          if (int'(shift_cnt) == conv_cycles - 1) begin
            state <= conv_done;
          end
        end
        default: state <= conv_idle;
      endcase
    end
  end

  // Digits of 5 and up get 3 added before the next shift
  always_comb begin
    for (int i = 0; i < 7; i++) begin
      acc_adj[i] = (acc_q[i] > 4'd4) ? acc_q[i] + 4'd3 : acc_q[i];
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      val_q <= fifo_mem[rd_ptr];
    end
    if (state == conv_load) begin
      neg_q <= (val_q < 0);
      // Most negative value maps to 2^23, still fits unsigned
      bin_q <= (val_q < 0) ? -val_q : val_q;
      acc_q <= '0;
    end
    if (state == conv_shift) begin
      {acc_q, bin_q} <= {acc_adj, bin_q} << 1;
    end
  end

  assign conv_valid    = (state == conv_done);
  assign conv_data.neg = neg_q;
  assign conv_data.mag = acc_q;

endmodule

/* design/tick_gen.sv */
`timescale 1ns/1ps

module tick_gen #(
  parameter int scan_div  = disp_timing_pkg::scan_div_default,
  parameter int blink_div = disp_timing_pkg::blink_div_default
) (
  input  logic clk,
  input  logic rst_n,
  input  logic blink_en,
  output logic scan_tick,
  output logic blink_phase
);

  logic [$clog2(scan_div + 1)-1:0]  scan_cnt;
  logic [$clog2(blink_div + 1)-1:0] blink_cnt;

  // Digit scan strobe, one clock wide
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scan_cnt  <= '0;
      scan_tick <= 1'b0;
    end else if (int'(scan_cnt) == scan_div - 1) begin
      scan_cnt  <= '0;
      scan_tick <= 1'b1;
    end else begin
      scan_cnt  <= scan_cnt + 1'b1;
      scan_tick <= 1'b0;
    end
  end

  // Blink phase only runs while blinking is requested
  always_ff @(posedge clk) begin
    if (!rst_n || !blink_en) begin
      blink_cnt   <= '0;
      blink_phase <= 1'b0;
    end else if (int'(blink_cnt) == blink_div - 1) begin
      blink_cnt   <= '0;
      blink_phase <= ~blink_phase;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

endmodule

/* design/disp_timing_pkg.sv */
package disp_timing_pkg;

  // Positions on the panel
  localparam int num_digits = 8;

  // Converter input buffer depth, also the sender's starting credits
  localparam int credit_depth = 2;

  // Clocks per digit, 1 kHz scan at 100 MHz
  localparam int scan_div_default = 100_000;

  // Clocks per blink half period, roughly 3 Hz blink
  localparam int blink_div_default = 16_000_000;

  // One shift per magnitude bit
  localparam int conv_cycles = 24;

endpackage

/* design/disp_types_pkg.sv */
package disp_types_pkg;

  // Display value as sent over the credit link, two's complement
  typedef logic signed [23:0] value_t;

  // One decimal digit
  typedef logic [3:0] bcd_t;

  // What a single display position shows
  typedef enum logic [3:0] {
    glyph_0, glyph_1, glyph_2, glyph_3, glyph_4,
    glyph_5, glyph_6, glyph_7, glyph_8, glyph_9,
    glyph_minus = 4'd10,
    glyph_blank = 4'd11
  } glyph_t;

  // Whole panel, digit[7] is the leftmost position
  typedef struct packed {
    glyph_t [7:0] digit;
  } frame_t;

  // Converter result in sign and magnitude form
  typedef struct packed {
    logic       neg;
    bcd_t [6:0] mag;
  } conv_out_t;

  typedef enum logic [1:0] {
    conv_idle,
    conv_load,
    conv_shift,
    conv_done
  } conv_state_t;

  // Active-low segments, bit order dp g f e d c b a
  function automatic logic [7:0] glyph_to_seg(glyph_t g);
    logic [6:0] lit;
    case (g)
      glyph_0:     lit = 7'h3f;
      glyph_1:     lit = 7'h06;
      glyph_2:     lit = 7'h5b;
      glyph_3:     lit = 7'h4f;
      glyph_4:     lit = 7'h66;
      glyph_5:     lit = 7'h6d;
      glyph_6:     lit = 7'h7d;
      glyph_7:     lit = 7'h07;
      glyph_8:     lit = 7'h7f;
      glyph_9:     lit = 7'h6f;
      glyph_minus: lit = 7'h40;
      default:     lit = 7'h00;
    endcase
    // Decimal point stays dark
    return ~{1'b0, lit};
  endfunction

endpackage
